//--- files.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
reg_file.sv
operand_bypass.sv
branch_unit.sv
decode_stage.sv
tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - inst_decoder.sv
  - reg_file.sv
  - operand_bypass.sv
  - branch_unit.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

//--- tb_decode_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_decode_stage;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 10;
  localparam int num_tests    = 6;
  localparam int test_cycles  = 200;  // Longest test is under 100 cycles.
  localparam int accept_limit = 50;

  logic                       clk;
  logic                       reset;
  logic                       fs_to_ds_valid;
  pipe_pkg::fetch_to_decode_t fetch;
  logic                       es_allowin;
  pipe_pkg::bypass_t          exec_fwd;
  pipe_pkg::bypass_t          mem_fwd;
  pipe_pkg::writeback_t       wb;
  logic                       ds_allowin;
  logic                       ds_to_es_valid;
  pipe_pkg::decode_to_exec_t  ds_to_es;
  pipe_pkg::branch_t          br;

  logic [`CPU_XLEN-1:0]       model_regs [`CPU_NUM_REGS];
  logic [31:0]                rng_state = 32'h13a1;
  pipe_pkg::fetch_to_decode_t cur;  // Instruction now expected in decode.

  decode_stage dut_i (
    .clk            (clk),
    .reset          (reset),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fetch          (fetch),
    .ds_allowin     (ds_allowin),
    .br             (br),
    .es_allowin     (es_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es),
    .exec_fwd       (exec_fwd),
    .mem_fwd        (mem_fwd),
    .wb             (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((reset_cycles + num_tests * test_cycles) * clk_period);
    fail_run("Timeout: the tests did not finish in the expected time.");
  end

  // Register contents as the writeback port defines them.
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        model_regs[i] <= '0;
      end
    end else if (wb.we && wb.addr != '0) begin
      model_regs[wb.addr] <= wb.data;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(next_rand() % 31) + 5'd1;
  endfunction

  function automatic logic [31:0] rand_pc();
    return next_rand() & 32'hffff_fffc;
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sa);
    return {6'h00, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic pipe_pkg::bypass_t make_fwd(input logic is_load, input logic [4:0] dest,
                                                 input logic [31:0] result);
    return '{valid: 1'b1, gr_we: 1'b1, is_load: is_load, dest: dest, result: result};
  endfunction

  // Forwarding priority is execute, memory, writeback, then the register file.
  function automatic logic [31:0] expect_operand(input logic [4:0] addr);
    if (addr == 5'd0) return '0;
    if (exec_fwd.valid && exec_fwd.gr_we && !exec_fwd.is_load && exec_fwd.dest == addr)
      return exec_fwd.result;
    if (mem_fwd.valid && mem_fwd.gr_we && !mem_fwd.is_load && mem_fwd.dest == addr)
      return mem_fwd.result;
    if (wb.we && wb.addr == addr) return wb.data;
    return model_regs[addr];
  endfunction

  function automatic pipe_pkg::decode_to_exec_t ref_decode(input pipe_pkg::fetch_to_decode_t f);
    pipe_pkg::decode_to_exec_t d;
    logic [31:0]               w;
    logic [5:0]                op, fn;
    logic [4:0]                rs, rt, rd, sa;
    logic                      ok, shift;
    w          = f.inst;
    op         = w[31:26];
    rs         = w[25:21];
    rt         = w[20:16];
    rd         = w[15:11];
    sa         = w[10:6];
    fn         = w[5:0];
    d          = '0;
    d.alu_op   = isa_pkg::alu_add;
    d.imm      = w[15:0];
    d.rs_value = expect_operand(rs);
    d.rt_value = expect_operand(rt);
    d.pc       = f.pc;
    case (op)
      6'h00: begin
        shift = fn inside {6'h00, 6'h02, 6'h03};
        ok    = 1'b1;
        case (fn)
          6'h00:   d.alu_op = isa_pkg::alu_sll;
          6'h02:   d.alu_op = isa_pkg::alu_srl;
          6'h03:   d.alu_op = isa_pkg::alu_sra;
          6'h21:   d.alu_op = isa_pkg::alu_add;
          6'h23:   d.alu_op = isa_pkg::alu_sub;
          6'h2a:   d.alu_op = isa_pkg::alu_slt;
          6'h2b:   d.alu_op = isa_pkg::alu_sltu;
          6'h24:   d.alu_op = isa_pkg::alu_and;
          6'h25:   d.alu_op = isa_pkg::alu_or;
          6'h26:   d.alu_op = isa_pkg::alu_xor;
          6'h27:   d.alu_op = isa_pkg::alu_nor;
          default: ok = 1'b0;  // jr and unknown functions write nothing.
        endcase
        if (ok && (shift ? rs == 5'd0 : sa == 5'd0)) begin
          d.src1_is_sa = shift;
          d.gr_we      = 1'b1;
          d.dest       = rd;
        end else begin
          d.alu_op = isa_pkg::alu_add;
        end
      end
      6'h03: begin
        d.src1_is_pc = 1'b1;
        d.src2_is_8  = 1'b1;
        d.gr_we      = 1'b1;
        d.dest       = 5'(`CPU_LINK_REG);
      end
      6'h09, 6'h0a, 6'h0b, 6'h23: begin
        d.src2_is_imm = 1'b1;
        d.gr_we       = 1'b1;
        d.dest        = rt;
        d.mem_re      = op == 6'h23;
        if (op == 6'h0a) d.alu_op = isa_pkg::alu_slt;
        if (op == 6'h0b) d.alu_op = isa_pkg::alu_sltu;
      end
      6'h0c, 6'h0d, 6'h0e: begin
        d.src2_is_uimm = 1'b1;
        d.gr_we        = 1'b1;
        d.dest         = rt;
        if (op == 6'h0c) d.alu_op = isa_pkg::alu_and;
        if (op == 6'h0d) d.alu_op = isa_pkg::alu_or;
        if (op == 6'h0e) d.alu_op = isa_pkg::alu_xor;
      end
      6'h0f: begin
        if (rs == 5'd0) begin
          d.alu_op      = isa_pkg::alu_lui;
          d.src2_is_imm = 1'b1;
          d.gr_we       = 1'b1;
          d.dest        = rt;
        end
      end
      6'h2b: begin
        d.src2_is_imm = 1'b1;
        d.mem_we      = 1'b1;
      end
      default: ;
    endcase
    return d;
  endfunction

  function automatic pipe_pkg::branch_t ref_branch(input pipe_pkg::fetch_to_decode_t f,
                                                   input logic fire);
    pipe_pkg::branch_t b;
    logic [31:0]       w, pc4, rs_v, rt_v;
    logic              cond;
    w        = f.inst;
    pc4      = f.pc + 32'd4;
    rs_v     = expect_operand(w[25:21]);
    rt_v     = expect_operand(w[20:16]);
    cond     = 1'b0;
    b.target = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
    case (w[31:26])
      6'h04: cond = rs_v == rt_v;
      6'h05: cond = rs_v != rt_v;
      6'h01: begin
        if (w[20:16] == 5'h01) cond = !rs_v[31];
        else if (w[20:16] == 5'h00) cond = rs_v[31];
      end
      6'h02, 6'h03: begin
        cond     = 1'b1;
        b.target = {pc4[31:28], w[25:0], 2'b00};
      end
      6'h00: begin
        if (w[5:0] == 6'h08 && w[20:6] == '0) begin
          cond     = 1'b1;
          b.target = rs_v;
        end
      end
      default: ;
    endcase
    b.taken = fire && cond;
    return b;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic compare_exec(input string name, input pipe_pkg::decode_to_exec_t exp,
                              input pipe_pkg::decode_to_exec_t act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_branch(input string name, input pipe_pkg::branch_t exp,
                                input pipe_pkg::branch_t act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s: expected taken %0b target %h, actual taken %0b target %h",
                         name, exp.taken, exp.target, act.taken, act.target));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s: expected %0b, actual %0b", name, exp, act));
  endtask

  // Called just after a falling edge. Returns one step after the edge that follows acceptance.
  task automatic issue(input logic [31:0] pc, input logic [31:0] word);
    int waited;
    waited         = 0;
    cur            = {pc, word};
    fetch          = cur;
    fs_to_ds_valid = 1'b1;
    #1;
    while (!ds_allowin) begin
      if (waited == accept_limit) fail_run("Decode never accepted the fetched instruction.");
      @(negedge clk);
      #1;
      waited++;
    end
    @(posedge clk);
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    #1;
  endtask

  task automatic check_decode(input string name);
    compare_exec(name, ref_decode(cur), ds_to_es);
    compare_bit({name, " valid"}, 1'b1, ds_to_es_valid);
  endtask

  task automatic check_stalled(input string name);
    compare_bit({name, " valid"}, 1'b0, ds_to_es_valid);
    compare_bit({name, " allowin"}, 1'b0, ds_allowin);
    compare_bit({name, " branch taken"}, 1'b0, br.taken);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk);
    wb = '{we: 1'b1, addr: addr, data: data};
    @(negedge clk);
    wb = '0;
  endtask

  task automatic test_alu_decode();
    logic [5:0] rfn [11] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27,
                            6'h00, 6'h02, 6'h03};
    logic [5:0] iop [6] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e};
    logic [4:0] rs, sa;
    for (int r = 1; r < `CPU_NUM_REGS; r++) begin
      @(negedge clk);
      wb = '{we: 1'b1, addr: 5'(r), data: next_rand()};
    end
    @(negedge clk);
    wb = '0;
    foreach (rfn[i]) begin
      rs = (i >= 8) ? 5'd0 : rand_reg();  // Shifts take sa in place of rs.
      sa = (i >= 8) ? 5'(next_rand()) : 5'd0;
      @(negedge clk);
      issue(rand_pc(), enc_r(rfn[i], rs, rand_reg(), rand_reg(), sa));
      check_decode($sformatf("R-type funct %h", rfn[i]));
    end
    foreach (iop[i]) begin
      @(negedge clk);
      issue(rand_pc(), enc_i(iop[i], rand_reg(), rand_reg(), 16'(next_rand())));
      check_decode($sformatf("I-type opcode %h", iop[i]));
    end
  endtask

  task automatic test_mem_decode();
    logic [31:0] words [4];
    string       names [4] = '{"lw", "sw", "lui", "unlisted opcode"};
    words[0] = enc_i(6'h23, rand_reg(), rand_reg(), 16'(next_rand()));
    words[1] = enc_i(6'h2b, rand_reg(), rand_reg(), 16'(next_rand()));
    words[2] = enc_i(6'h0f, 5'd0, rand_reg(), 16'(next_rand()));
    words[3] = enc_i(6'h3f, rand_reg(), rand_reg(), 16'(next_rand()));
    foreach (words[i]) begin
      @(negedge clk);
      issue(rand_pc(), words[i]);
      check_decode(names[i]);
      compare_bit({names[i], " branch taken"}, 1'b0, br.taken);
    end
  endtask

  task automatic test_forwarding();
    logic [4:0]  r;
    logic [31:0] a, c, word;
    r    = rand_reg();
    a    = next_rand();
    c    = next_rand();
    word = enc_r(6'h21, r, rand_reg(), rand_reg(), 5'd0);
    @(negedge clk);
    es_allowin = 1'b0;  // The instruction stays in decode while its sources change.
    issue(rand_pc(), word);
    @(negedge clk);
    exec_fwd = make_fwd(1'b0, r, a);
    mem_fwd  = make_fwd(1'b0, r, ~a);
    wb       = '{we: 1'b1, addr: r, data: c};
    #1;
    check_decode("forward from execute");
    compare_bit("execute result chosen", 1'b1, ds_to_es.rs_value == a);
    @(negedge clk);
    exec_fwd.valid = 1'b0;
    #1;
    check_decode("forward from memory");
    compare_bit("memory result chosen", 1'b1, ds_to_es.rs_value == ~a);
    @(negedge clk);
    mem_fwd.gr_we = 1'b0;
    wb            = '{we: 1'b1, addr: r, data: ~c};  // The file still holds c.
    #1;
    check_decode("forward from writeback");
    compare_bit("writeback data chosen", 1'b1, ds_to_es.rs_value == ~c);
    @(negedge clk);
    wb = '0;
    #1;
    check_decode("register file after write");
    compare_bit("register file value", 1'b1, ds_to_es.rs_value == ~c);
    @(negedge clk);
    es_allowin = 1'b1;
    exec_fwd   = make_fwd(1'b0, 5'd0, a);
    mem_fwd    = make_fwd(1'b0, 5'd0, ~a);
    wb         = '{we: 1'b1, addr: 5'd0, data: a};
    issue(rand_pc(), enc_r(6'h21, 5'd0, 5'd0, rand_reg(), 5'd0));
    check_decode("register zero");
    compare_bit("register zero reads zero", 1'b1, ds_to_es.rs_value == '0);
    @(negedge clk);
    exec_fwd = '0;
    mem_fwd  = '0;
    wb       = '0;
  endtask

  task automatic test_load_use_stall();
    logic [4:0]  r;
    logic [31:0] d;
    r = rand_reg();
    d = next_rand();
    @(negedge clk);
    exec_fwd = make_fwd(1'b1, r, next_rand());
    issue(rand_pc(), enc_i(6'h04, r, r, 16'(next_rand())));
    check_stalled("load in execute");
    repeat (2) begin
      @(negedge clk);
      #1;
      check_stalled("load in execute");
    end
    @(negedge clk);
    exec_fwd = '0;
    mem_fwd  = make_fwd(1'b1, r, next_rand());
    #1;
    check_stalled("load in memory");
    @(negedge clk);
    mem_fwd = '0;
    wb      = '{we: 1'b1, addr: r, data: d};  // The load data arrives from writeback.
    #1;
    check_decode("after load-use stall");
    compare_bit("loaded value forwarded", 1'b1, ds_to_es.rs_value == d);
    compare_branch("beq after stall", ref_branch(cur, 1'b1), br);
    @(negedge clk);
    wb = '0;
  endtask

  task automatic test_branches();
    logic [31:0] words [7];
    string       names [7] = '{"beq", "bne", "bgez", "bltz", "j", "jal", "jr"};
    logic [4:0]  ra, rb;
    logic [31:0] va;
    for (int p = 0; p < 2; p++) begin
      ra     = rand_reg();
      rb     = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
      va     = next_rand() & 32'h7fff_ffff;
      va[31] = (p == 0);  // Sign bit set on the first pass.
      write_reg(ra, va);
      write_reg(rb, (p == 1) ? va : ~va);
      words[0] = enc_i(6'h04, ra, rb, 16'(next_rand()));
      words[1] = enc_i(6'h05, ra, rb, 16'(next_rand()));
      words[2] = enc_i(6'h01, ra, 5'h01, 16'(next_rand()));
      words[3] = enc_i(6'h01, ra, 5'h00, 16'(next_rand()));
      words[4] = {6'h02, 26'(next_rand())};
      words[5] = {6'h03, 26'(next_rand())};
      words[6] = enc_r(6'h08, ra, 5'd0, 5'd0, 5'd0);
      foreach (words[i]) begin
        @(negedge clk);
        issue(rand_pc(), words[i]);
        check_decode(names[i]);
        compare_branch($sformatf("%s pass %0d", names[i], p), ref_branch(cur, 1'b1), br);
      end
    end
  endtask

  task automatic test_back_pressure();
    pipe_pkg::fetch_to_decode_t held;
    logic [31:0]                pc_b, word_b;
    pc_b   = rand_pc();
    word_b = enc_r(6'h25, rand_reg(), rand_reg(), rand_reg(), 5'd0);
    @(negedge clk);
    es_allowin = 1'b0;
    issue(rand_pc(), enc_i(6'h09, rand_reg(), rand_reg(), 16'(next_rand())));
    held = cur;
    @(negedge clk);
    fetch          = {pc_b, word_b};
    fs_to_ds_valid = 1'b1;
    repeat (5) begin
      #1;
      compare_exec("held output", ref_decode(held), ds_to_es);
      compare_bit("held allowin", 1'b0, ds_allowin);
      compare_bit("held valid", 1'b1, ds_to_es_valid);
      @(negedge clk);
    end
    es_allowin = 1'b1;
    #1;
    compare_bit("allowin after release", 1'b1, ds_allowin);
    @(posedge clk);
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    cur            = {pc_b, word_b};
    #1;
    check_decode("fetch after release");
  endtask

  initial begin
    reset          = 1'b1;
    fs_to_ds_valid = 1'b0;
    fetch          = '0;
    es_allowin     = 1'b1;
    exec_fwd       = '0;
    mem_fwd        = '0;
    wb             = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    compare_bit("valid after reset", 1'b0, ds_to_es_valid);
    compare_bit("branch after reset", 1'b0, br.taken);
    test_alu_decode();
    test_mem_decode();
    test_forwarding();
    test_load_use_stall();
    test_branches();
    test_back_pressure();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decode_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       fs_to_ds_valid,
  input  pipe_pkg::fetch_to_decode_t fetch,
  output logic                       ds_allowin,
  output pipe_pkg::branch_t          br,
  input  logic                       es_allowin,
  output logic                       ds_to_es_valid,
  output pipe_pkg::decode_to_exec_t  ds_to_es,
  input  pipe_pkg::bypass_t          exec_fwd,
  input  pipe_pkg::bypass_t          mem_fwd,
  input  pipe_pkg::writeback_t       wb
);

  pipe_pkg::fetch_to_decode_t fetch_q;
  logic                       ds_valid;
  logic                       ds_ready_go;
  logic                       stall;
  logic [`CPU_XLEN-1:0]       ds_inst;
  logic [`CPU_XLEN-1:0]       rf_rdata1;
  logic [`CPU_XLEN-1:0]       rf_rdata2;
  logic [`CPU_XLEN-1:0]       rs_value;
  logic [`CPU_XLEN-1:0]       rt_value;
  isa_pkg::alu_op_e           alu_op;
  logic                       src1_is_sa;
  logic                       src1_is_pc;
  logic                       src2_is_imm;
  logic                       src2_is_uimm;
  logic                       src2_is_8;
  logic                       mem_re;
  logic                       mem_we;
  logic                       gr_we;
  logic [`CPU_REG_AW-1:0]     dest;
  isa_pkg::branch_e           branch;

  assign ds_ready_go    = !stall;
  assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
  assign ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge clk) begin
    if (reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_to_ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_to_ds_valid && ds_allowin) begin
      fetch_q <= fetch;
    end
  end

  assign ds_inst  = fetch_q.inst;
  assign ds_to_es = '{alu_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm,
                      src2_is_8, mem_re, mem_we, gr_we, dest,
                      ds_inst[`CPU_IMM_W-1:0], rs_value, rt_value, fetch_q.pc};

  inst_decoder u_decoder (
    .inst         (fetch_q.inst),
    .alu_op       (alu_op),
    .src1_is_sa   (src1_is_sa),
    .src1_is_pc   (src1_is_pc),
    .src2_is_imm  (src2_is_imm),
    .src2_is_uimm (src2_is_uimm),
    .src2_is_8    (src2_is_8),
    .mem_re       (mem_re),
    .mem_we       (mem_we),
    .gr_we        (gr_we),
    .dest         (dest),
    .branch       (branch)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .raddr1 (fetch_q.inst.rs),
    .raddr2 (fetch_q.inst.rt),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wr     (wb)
  );

  operand_bypass u_bypass (
    .rs        (fetch_q.inst.rs),
    .rt        (fetch_q.inst.rt),
    .rf_rdata1 (rf_rdata1),
    .rf_rdata2 (rf_rdata2),
    .exec_fwd  (exec_fwd),
    .mem_fwd   (mem_fwd),
    .wb        (wb),
    .rs_value  (rs_value),
    .rt_value  (rt_value),
    .stall     (stall)
  );

  branch_unit u_branch (
    .branch   (branch),
    .fire     (ds_to_es_valid),
    .pc       (fetch_q.pc),
    .inst     (fetch_q.inst),
    .rs_value (rs_value),
    .rt_value (rt_value),
    .br       (br)
  );

endmodule

//--- branch_unit.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module branch_unit (
  input  isa_pkg::branch_e      branch,
  input  logic                  fire,
  input  logic [`CPU_XLEN-1:0]  pc,
  input  isa_pkg::inst_fields_t inst,
  input  logic [`CPU_XLEN-1:0]  rs_value,
  input  logic [`CPU_XLEN-1:0]  rt_value,
  output pipe_pkg::branch_t     br
);

  logic [`CPU_XLEN-1:0]   inst_word;
  logic [`CPU_IMM_W-1:0]  imm;
  logic [`CPU_JIDX_W-1:0] jidx;
  logic [`CPU_XLEN-1:0]   pc_plus4;
  logic [`CPU_XLEN-1:0]   rel_target;
  logic [`CPU_XLEN-1:0]   abs_target;
  logic [`CPU_XLEN-1:0]   target;
  logic                   cond;

  assign inst_word  = inst;
  assign imm        = inst_word[`CPU_IMM_W-1:0];
  assign jidx       = inst_word[`CPU_JIDX_W-1:0];
  assign pc_plus4   = pc + `CPU_XLEN'(4);
  assign rel_target = pc_plus4 + {{(`CPU_XLEN-`CPU_IMM_W-2){imm[`CPU_IMM_W-1]}}, imm, 2'b00};
  assign abs_target = {pc_plus4[`CPU_XLEN-1:`CPU_JIDX_W+2], jidx, 2'b00};

  always_comb begin
    cond   = 1'b0;
    target = rel_target;
    case (branch)
      isa_pkg::br_beq:  cond = rs_value == rt_value;
      isa_pkg::br_bne:  cond = rs_value != rt_value;
      isa_pkg::br_bgez: cond = !rs_value[`CPU_XLEN-1];  // Sign bit clear.
      isa_pkg::br_bltz: cond = rs_value[`CPU_XLEN-1];
      isa_pkg::br_j, isa_pkg::br_jal: begin
        cond   = 1'b1;
        target = abs_target;
      end
      isa_pkg::br_jr: begin
        cond   = 1'b1;
        target = rs_value;
      end
      default: ;
    endcase
  end

  // Fetch only redirects once the branch leaves decode.
  assign br = '{taken: fire && cond, target: target};

endmodule

//--- operand_bypass.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module operand_bypass (
  input  logic [`CPU_REG_AW-1:0] rs,
  input  logic [`CPU_REG_AW-1:0] rt,
  input  logic [`CPU_XLEN-1:0]   rf_rdata1,
  input  logic [`CPU_XLEN-1:0]   rf_rdata2,
  input  pipe_pkg::bypass_t      exec_fwd,
  input  pipe_pkg::bypass_t      mem_fwd,
  input  pipe_pkg::writeback_t   wb,
  output logic [`CPU_XLEN-1:0]   rs_value,
  output logic [`CPU_XLEN-1:0]   rt_value,
  output logic                   stall
);

  // True when the stage will write register addr. Register 0 never matches.
  function automatic logic fwd_hit(input pipe_pkg::bypass_t      f,
                                   input logic [`CPU_REG_AW-1:0] addr);
    return f.valid && f.gr_we && f.dest != '0 && f.dest == addr;
  endfunction

  function automatic logic [`CPU_XLEN-1:0] pick_operand(
    input logic [`CPU_REG_AW-1:0] addr,
    input logic [`CPU_XLEN-1:0]   rf_data,
    input pipe_pkg::bypass_t      e,
    input pipe_pkg::bypass_t      m,
    input pipe_pkg::writeback_t   w
  );
    return (fwd_hit(e, addr) && !e.is_load)          ? e.result :
           (fwd_hit(m, addr) && !m.is_load)          ? m.result :
           (w.we && w.addr != '0 && w.addr == addr)  ? w.data   :
                                                       rf_data;
  endfunction

  assign rs_value = pick_operand(rs, rf_rdata1, exec_fwd, mem_fwd, wb);
  assign rt_value = pick_operand(rt, rf_rdata2, exec_fwd, mem_fwd, wb);

  // A load in execute or memory has no data yet, so decode waits for it.
  assign stall = (exec_fwd.is_load && (fwd_hit(exec_fwd, rs) || fwd_hit(exec_fwd, rt))) ||
                 (mem_fwd.is_load  && (fwd_hit(mem_fwd, rs)  || fwd_hit(mem_fwd, rt)));

endmodule

//--- reg_file.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CPU_REG_AW-1:0] raddr1,
  input  logic [`CPU_REG_AW-1:0] raddr2,
  output logic [`CPU_XLEN-1:0]   rdata1,
  output logic [`CPU_XLEN-1:0]   rdata2,
  input  pipe_pkg::writeback_t   wr
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.addr != '0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // The read does not see a write in the same cycle; the bypass covers that.
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- inst_decoder.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module inst_decoder (
  input  isa_pkg::inst_fields_t  inst,
  output isa_pkg::alu_op_e       alu_op,
  output logic                   src1_is_sa,
  output logic                   src1_is_pc,
  output logic                   src2_is_imm,
  output logic                   src2_is_uimm,
  output logic                   src2_is_8,
  output logic                   mem_re,
  output logic                   mem_we,
  output logic                   gr_we,
  output logic [`CPU_REG_AW-1:0] dest,
  output isa_pkg::branch_e       branch
);

  isa_pkg::alu_op_e r_op;
  isa_pkg::alu_op_e i_op;
  logic             r_known;
  logic             r_shift;
  logic             r_ok;
  logic             jr_ok;
  logic             wr_rt;

  always_comb begin
    r_op    = isa_pkg::alu_add;
    r_known = 1'b1;
    case (inst.funct)
      isa_pkg::fn_addu: r_op = isa_pkg::alu_add;
      isa_pkg::fn_subu: r_op = isa_pkg::alu_sub;
      isa_pkg::fn_slt:  r_op = isa_pkg::alu_slt;
      isa_pkg::fn_sltu: r_op = isa_pkg::alu_sltu;
      isa_pkg::fn_and:  r_op = isa_pkg::alu_and;
      isa_pkg::fn_or:   r_op = isa_pkg::alu_or;
      isa_pkg::fn_xor:  r_op = isa_pkg::alu_xor;
      isa_pkg::fn_nor:  r_op = isa_pkg::alu_nor;
      isa_pkg::fn_sll:  r_op = isa_pkg::alu_sll;
      isa_pkg::fn_srl:  r_op = isa_pkg::alu_srl;
      isa_pkg::fn_sra:  r_op = isa_pkg::alu_sra;
      default:          r_known = 1'b0;
    endcase
  end

  always_comb begin
    case (inst.opcode)
      isa_pkg::op_slti:  i_op = isa_pkg::alu_slt;
      isa_pkg::op_sltiu: i_op = isa_pkg::alu_sltu;
      isa_pkg::op_andi:  i_op = isa_pkg::alu_and;
      isa_pkg::op_ori:   i_op = isa_pkg::alu_or;
      isa_pkg::op_xori:  i_op = isa_pkg::alu_xor;
      isa_pkg::op_lui:   i_op = isa_pkg::alu_lui;
      default:           i_op = isa_pkg::alu_add;  // addiu and lw add to rs.
    endcase
  end

  // Shifts need rs zero and the other R-type operations need sa zero.
  assign r_shift = inst.funct inside {isa_pkg::fn_sll, isa_pkg::fn_srl, isa_pkg::fn_sra};
  assign r_ok    = r_known && (r_shift ? inst.rs == '0 : inst.sa == '0);
  assign jr_ok   = inst.funct == isa_pkg::fn_jr && inst.rt == '0 && inst.rd == '0 &&
                   inst.sa == '0;

  always_comb begin
    alu_op       = isa_pkg::alu_add;
    src1_is_sa   = 1'b0;
    src1_is_pc   = 1'b0;
    src2_is_imm  = 1'b0;
    src2_is_uimm = 1'b0;
    src2_is_8    = 1'b0;
    mem_re       = 1'b0;
    mem_we       = 1'b0;
    gr_we        = 1'b0;
    dest         = '0;
    branch       = isa_pkg::br_none;
    wr_rt        = 1'b0;
    case (inst.opcode)
      isa_pkg::op_special: begin
        if (r_ok) begin
          alu_op     = r_op;
          src1_is_sa = r_shift;
          gr_we      = 1'b1;
          dest       = inst.rd;
        end else if (jr_ok) begin
          branch = isa_pkg::br_jr;
        end
      end
      isa_pkg::op_regimm: begin
        if (inst.rt == isa_pkg::ri_bgez) begin
          branch = isa_pkg::br_bgez;
        end else if (inst.rt == isa_pkg::ri_bltz) begin
          branch = isa_pkg::br_bltz;
        end
      end
      isa_pkg::op_j:   branch = isa_pkg::br_j;
      isa_pkg::op_beq: branch = isa_pkg::br_beq;
      isa_pkg::op_bne: branch = isa_pkg::br_bne;
      isa_pkg::op_jal: begin
        branch     = isa_pkg::br_jal;
        src1_is_pc = 1'b1;              // Link value is pc + 8.
        src2_is_8  = 1'b1;
        gr_we      = 1'b1;
        dest       = `CPU_REG_AW'(`CPU_LINK_REG);
      end
      isa_pkg::op_addiu, isa_pkg::op_slti, isa_pkg::op_sltiu, isa_pkg::op_lw: begin
        src2_is_imm = 1'b1;
        wr_rt       = 1'b1;
      end
      isa_pkg::op_andi, isa_pkg::op_ori, isa_pkg::op_xori: begin
        src2_is_uimm = 1'b1;
        wr_rt        = 1'b1;
      end
      isa_pkg::op_lui: begin
        src2_is_imm = inst.rs == '0;
        wr_rt       = inst.rs == '0;
      end
      isa_pkg::op_sw: begin
        src2_is_imm = 1'b1;
        mem_we      = 1'b1;
      end
      default: ;
    endcase
    if (wr_rt) begin
      alu_op = i_op;
      gr_we  = 1'b1;
      dest   = inst.rt;
      mem_re = inst.opcode == isa_pkg::op_lw;
    end
  end

endmodule

//--- pipe_pkg.sv
`include "cpu_defines.svh"

package pipe_pkg;

  typedef struct packed {
    logic [`CPU_XLEN-1:0]  pc;
    isa_pkg::inst_fields_t inst;
  } fetch_to_decode_t;

  typedef struct packed {
    isa_pkg::alu_op_e       alu_op;
    logic                   src1_is_sa;   // Shift amount replaces rs.
    logic                   src1_is_pc;
    logic                   src2_is_imm;  // Sign-extended immediate.
    logic                   src2_is_uimm; // Zero-extended immediate.
    logic                   src2_is_8;
    logic                   mem_re;
    logic                   mem_we;
    logic                   gr_we;
    logic [`CPU_REG_AW-1:0] dest;
    logic [`CPU_IMM_W-1:0]  imm;
    logic [`CPU_XLEN-1:0]   rs_value;
    logic [`CPU_XLEN-1:0]   rt_value;
    logic [`CPU_XLEN-1:0]   pc;
  } decode_to_exec_t;

  // Snapshot of the instruction now in a later stage.
  typedef struct packed {
    logic                   valid;
    logic                   gr_we;
    logic                   is_load;      // Result not known until writeback.
    logic [`CPU_REG_AW-1:0] dest;
    logic [`CPU_XLEN-1:0]   result;
  } bypass_t;

  typedef struct packed {
    logic                   we;
    logic [`CPU_REG_AW-1:0] addr;
    logic [`CPU_XLEN-1:0]   data;
  } writeback_t;

  typedef struct packed {
    logic                 taken;
    logic [`CPU_XLEN-1:0] target;
  } branch_t;

endpackage

//--- isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

  typedef enum logic [`CPU_OP_W-1:0] {
    op_special = 6'h00,
    op_regimm  = 6'h01,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_sltiu   = 6'h0b,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  typedef enum logic [`CPU_FUNCT_W-1:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_sra  = 6'h03,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_e;

  typedef enum logic [`CPU_REG_AW-1:0] {
    ri_bltz = 5'h00,
    ri_bgez = 5'h01
  } regimm_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_beq, br_bne, br_bgez, br_bltz, br_j, br_jal, br_jr
  } branch_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [`CPU_REG_AW-1:0] rs;
    logic [`CPU_REG_AW-1:0] rt;     // Also the regimm code.
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_SA_W-1:0]   sa;
    funct_e                 funct;
  } inst_fields_t;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and general register file.
`define CPU_XLEN      32
`define CPU_REG_AW    5
`define CPU_NUM_REGS  32
`define CPU_LINK_REG  31

// Instruction field widths.
// The fields sit in MIPS32 order, so these widths also fix their bit positions.
`define CPU_OP_W      6
`define CPU_SA_W      5
`define CPU_FUNCT_W   6
`define CPU_IMM_W     16
`define CPU_JIDX_W    26

`endif
